// ==== src/irq_cfg.svh ====
// ##########################################################
// Interrupt controller sizing, vector layout and priority bands
// ##########################################################
`ifndef IRQ_CFG_SVH
`define IRQ_CFG_SVH

`define IRQ_COUNT        16        // Request lines
`define IRQ_ID_W         4         // Bits of a line number
`define IRQ_NONE         4'hF      // Shown when nothing is active

// Vector address = base + (line << shift)
`define VEC_BASE         32'h1000
`define VEC_STRIDE_SHIFT 8

// First line of each lower band
`define PRIO_BAND_HIGH   2         // Lines 0..1 are level 3
`define PRIO_BAND_MID    6         // Lines 2..5 are level 2
`define PRIO_BAND_LOW    12        // Lines 6..11 level 1, rest level 0

`endif

// ==== src/irq_pkg.sv ====
// ##########################################################
// Shared types: priority level, grant and clear records
// ##########################################################
`include "irq_cfg.svh"

package irq_pkg;

    // 3 is the most urgent
    typedef logic [1:0] irq_level_t;

    // Winner of the priority scan
    typedef struct packed {
        logic                 valid;   // Some line is pending
        logic [`IRQ_ID_W-1:0] id;
        irq_level_t           level;
    } irq_grant_t;

    // Drop one line from the pending set
    typedef struct packed {
        logic                 valid;
        logic [`IRQ_ID_W-1:0] id;
    } irq_clear_t;

endpackage

// ==== src/irq_capture.sv ====
// ##########################################################
// Request masking and sticky pending set
// ##########################################################
`include "irq_cfg.svh"

module irq_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`IRQ_COUNT-1:0]   irq_lines,
    input  logic [31:0]             mask_register,
    input  irq_pkg::irq_clear_t     clear,
    output logic [`IRQ_COUNT-1:0]   pending
);

    logic [`IRQ_COUNT-1:0] masked_req;   // Requests that pass the mask
    logic [`IRQ_COUNT-1:0] clear_mask;   // One-hot of the acknowledged line

    // Only the low bits of the mask register map to lines
    assign masked_req = irq_lines & mask_register[`IRQ_COUNT-1:0];

    always_comb begin
        clear_mask = '0;
        if (clear.valid) begin
            clear_mask[clear.id] = 1'b1;
        end
    end

    // Clear first, then OR in new requests,
    // so a line still asserted on its acknowledge edge re-arms
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | masked_req;
        end
    end

endmodule

// ==== src/irq_priority.sv ====
// ##########################################################
// Fixed priority table and winner selection
// ##########################################################
`include "irq_cfg.svh"

module irq_priority (
    input  logic [`IRQ_COUNT-1:0]   pending,
    output irq_pkg::irq_grant_t     grant
);

    irq_pkg::irq_level_t  line_level [`IRQ_COUNT];   // Level of each line
    irq_pkg::irq_level_t  best_level;
    logic [`IRQ_ID_W-1:0] best_id;
    logic                 best_valid;

    // Band lookup from the config limits
    function automatic irq_pkg::irq_level_t level_of(input int line);
        irq_pkg::irq_level_t lvl;
        if (line < `PRIO_BAND_HIGH) begin
            lvl = 2'd3;
        end else if (line < `PRIO_BAND_MID) begin
            lvl = 2'd2;
        end else if (line < `PRIO_BAND_LOW) begin
            lvl = 2'd1;
        end else begin
            lvl = 2'd0;
        end
        return lvl;
    endfunction

    for (genvar g = 0; g < `IRQ_COUNT; g++) begin : g_level
        assign line_level[g] = level_of(g);
    end

    // Ascending scan with >= so the higher line takes ties
    always_comb begin
        best_valid = 1'b0;
        best_id    = `IRQ_NONE;
        best_level = '0;
        for (int i = 0; i < `IRQ_COUNT; i++) begin
            if (pending[i] && (!best_valid || line_level[i] >= best_level)) begin
                best_valid = 1'b1;
                best_id    = `IRQ_ID_W'(i);
                best_level = line_level[i];
            end
        end
    end

    assign grant.valid = best_valid;
    assign grant.id    = best_id;
    assign grant.level = best_level;

endmodule

// ==== src/irq_dispatch.sv ====
// ##########################################################
// Dispatch FSM: present winner, hold for acknowledge, clear
// ##########################################################
`include "irq_cfg.svh"

module irq_dispatch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`IRQ_COUNT-1:0]   pending,
    input  irq_pkg::irq_grant_t     grant,
    input  logic                    interrupt_ack,
    output irq_pkg::irq_clear_t     clear,
    output logic [`IRQ_ID_W-1:0]    active_irq,
    output logic                    interrupt_pending,
    output logic [31:0]             vector_addr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SELECT,
        ST_WAIT_ACK,
        ST_SERVICE
    } state_t;

    state_t      state;
    logic        ack_taken;     // Acknowledge accepted this cycle
    logic [31:0] grant_vector;  // Vector of the current winner

    // Acks outside wait_ack are dropped here
    assign ack_taken = (state == ST_WAIT_ACK) && interrupt_ack;

    assign grant_vector = `VEC_BASE + (32'(grant.id) << `VEC_STRIDE_SHIFT);

    // Clear reaches capture before the ack edge
    assign clear.valid = ack_taken;
    assign clear.id    = active_irq;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= ST_IDLE;
            active_irq        <= `IRQ_NONE;
            interrupt_pending <= 1'b0;
            vector_addr       <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pending != '0) begin
                        state <= ST_SELECT;
                    end
                end
                ST_SELECT: begin
                    if (grant.valid) begin
                        active_irq        <= grant.id;
                        vector_addr       <= grant_vector;
                        interrupt_pending <= 1'b1;
                        state             <= ST_WAIT_ACK;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_WAIT_ACK: begin
                    // Outputs frozen until the host answers
                    if (ack_taken) begin
                        interrupt_pending <= 1'b0;
                        state             <= ST_SERVICE;
                    end
                end
                ST_SERVICE: begin
                    active_irq <= `IRQ_NONE;   // vector_addr keeps last value
                    state      <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/irq_ctrl.sv ====
// ##########################################################
// Interrupt controller top: capture, priority, dispatch
// ##########################################################
`include "irq_cfg.svh"

module irq_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`IRQ_COUNT-1:0]   irq_lines,
    input  logic [31:0]             mask_register,
    input  logic                    interrupt_ack,
    output logic [`IRQ_ID_W-1:0]    active_irq,
    output logic                    interrupt_pending,
    output logic [31:0]             vector_addr
);

    logic [`IRQ_COUNT-1:0] pending;   // Sticky request set
    irq_pkg::irq_grant_t   grant;     // Combinational winner
    irq_pkg::irq_clear_t   clear;     // Ack feedback to capture

    irq_capture u_irq_capture (
        .clk           (clk),
        .rst           (rst),
        .irq_lines     (irq_lines),
        .mask_register (mask_register),
        .clear         (clear),
        .pending       (pending)
    );

    irq_priority u_irq_priority (
        .pending (pending),
        .grant   (grant)
    );

    irq_dispatch u_irq_dispatch (
        .clk               (clk),
        .rst               (rst),
        .pending           (pending),
        .grant             (grant),
        .interrupt_ack     (interrupt_ack),
        .clear             (clear),
        .active_irq        (active_irq),
        .interrupt_pending (interrupt_pending),
        .vector_addr       (vector_addr)
    );

endmodule

// ==== sim/irq_ctrl_tb.sv ====
// ##########################################################
// Testbench for irq_ctrl with directed cases, random traffic,
// a cycle model of capture, priority and dispatch, and a watchdog
// ##########################################################
`include "irq_cfg.svh"

module irq_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 4;
    localparam int DRIVE_DELAY     = 1;     // Inputs change this long after the edge
    localparam int RESET_CYCLES    = 3;
    localparam int PRESENT_LIMIT   = 20;    // Cycles allowed until a presentation
    localparam int DRAIN_LIMIT     = 200;
    localparam int DIRECTED_CYCLES = 400;
    localparam int RAND_CYCLES     = 4000;
    localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES
                                     + 5 * DRAIN_LIMIT;
    localparam int WATCHDOG_NS     = TEST_CYCLES * CLK_PERIOD * 2;

    // Model FSM states
    localparam int M_IDLE    = 0;
    localparam int M_SELECT  = 1;
    localparam int M_WAIT    = 2;
    localparam int M_SERVICE = 3;

    logic                    clk;
    logic                    rst;
    logic [`IRQ_COUNT-1:0]   irq_lines;
    logic [31:0]             mask_register;
    logic                    interrupt_ack;
    logic [`IRQ_ID_W-1:0]    active_irq;
    logic                    interrupt_pending;
    logic [31:0]             vector_addr;

    int seed = 32'h90c478f4;
    int errors = 0;
    int checks = 0;

    // Reference model state
    logic [`IRQ_COUNT-1:0]   m_pending;
    int                      m_state;
    logic [`IRQ_ID_W-1:0]    m_active;
    logic                    m_ipend;
    logic [31:0]             m_vec;

    irq_ctrl u_irq_ctrl (
        .clk               (clk),
        .rst               (rst),
        .irq_lines         (irq_lines),
        .mask_register     (mask_register),
        .interrupt_ack     (interrupt_ack),
        .active_irq        (active_irq),
        .interrupt_pending (interrupt_pending),
        .vector_addr       (vector_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the simulation ran past its time limit");
        $display("Done: errors found");
        $finish;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Level = 3 minus the number of band limits at or below the line
    function automatic int line_level(input int line);
        int lvl;
        lvl = 3;
        if (line >= `PRIO_BAND_HIGH) lvl--;
        if (line >= `PRIO_BAND_MID) lvl--;
        if (line >= `PRIO_BAND_LOW) lvl--;
        return lvl;
    endfunction

    // Highest level first, then highest line
    // Returns -1 when nothing is pending
    function automatic int pick_winner(input logic [`IRQ_COUNT-1:0] p);
        for (int lvl = 3; lvl >= 0; lvl--) begin
            for (int line = `IRQ_COUNT - 1; line >= 0; line--) begin
                if (p[line] && line_level(line) == lvl) begin
                    return line;
                end
            end
        end
        return -1;
    endfunction

    function automatic logic [31:0] vector_of(input int id);
        logic [31:0] vec;
        vec = `VEC_BASE;
        vec = vec + (32'(id) << `VEC_STRIDE_SHIFT);
        return vec;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: actual %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // One rising edge of the model fed with the inputs the DUT just sampled
    task automatic update_model();
        logic [`IRQ_COUNT-1:0] clr;
        int                    win;
        clr = '0;
        if (m_state == M_WAIT && interrupt_ack) begin
            clr[m_active] = 1'b1;
        end
        win = pick_winner(m_pending);
        case (m_state)
            M_IDLE: begin
                if (m_pending != '0) m_state = M_SELECT;
            end
            M_SELECT: begin
                if (win >= 0) begin
                    m_active = `IRQ_ID_W'(win);
                    m_vec    = vector_of(win);
                    m_ipend  = 1'b1;
                    m_state  = M_WAIT;
                end else begin
                    m_state = M_IDLE;
                end
            end
            M_WAIT: begin
                if (interrupt_ack) begin
                    m_ipend = 1'b0;
                    m_state = M_SERVICE;
                end
            end
            default: begin
                m_active = `IRQ_NONE;
                m_state  = M_IDLE;
            end
        endcase
        m_pending = (m_pending & ~clr) | (irq_lines & mask_register[`IRQ_COUNT-1:0]);
    endtask

    // Advance one cycle and compare every output with the model
    task automatic advance_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        update_model();
        check_value("interrupt_pending", 32'(interrupt_pending), 32'(m_ipend));
        check_value("active_irq", 32'(active_irq), 32'(m_active));
        check_value("vector_addr", vector_addr, m_vec);
    endtask

    task automatic wait_for_presentation(output int edges);
        edges = 0;
        while (!interrupt_pending && edges < PRESENT_LIMIT) begin
            advance_cycle();
            edges++;
        end
        if (!interrupt_pending) begin
            errors++;
            $display("No interrupt was presented within %0d cycles", PRESENT_LIMIT);
        end
    endtask

    // Keep acknowledging until the model is idle with nothing pending
    task automatic drain_pending();
        int n;
        n = 0;
        irq_lines = '0;
        while ((m_pending != '0 || m_state != M_IDLE) && n < DRAIN_LIMIT) begin
            advance_cycle();
            interrupt_ack = m_ipend;
            n++;
        end
        interrupt_ack = 1'b0;
        if (m_pending != '0 || m_state != M_IDLE) begin
            errors++;
            $display("Controller did not drain within %0d cycles", DRAIN_LIMIT);
        end
    endtask

    // Expect a line, withhold the ack for hold cycles, inject requests meanwhile
    task automatic serve_expected(input int exp_id, input int hold,
                                  input logic [`IRQ_COUNT-1:0] inject);
        int edges;
        wait_for_presentation(edges);
        check_value("active_irq", 32'(active_irq), 32'(exp_id));
        check_value("vector_addr", vector_addr, vector_of(exp_id));
        irq_lines = inject;
        for (int i = 0; i < hold; i++) begin
            advance_cycle();
            irq_lines = '0;
        end
        interrupt_ack = 1'b1;
        advance_cycle();
        interrupt_ack = 1'b0;
        irq_lines     = '0;
    endtask

    task automatic run_random(input int n_cycles);
        logic [`IRQ_COUNT-1:0] lines;
        int                    hold_line;
        int                    hold_left;
        int                    ack_delay;
        logic                  armed;
        hold_line = 0;
        hold_left = 0;
        ack_delay = 0;
        armed     = 1'b0;
        for (int c = 0; c < n_cycles; c++) begin
            advance_cycle();
            if (c % 48 == 0) begin
                mask_register = 32'($random(seed));
                if (rand_below(4) == 0) mask_register[`IRQ_COUNT-1:0] = '1;
            end
            lines = '0;
            if (rand_below(6) == 0) lines = 16'(1) << rand_below(16);
            if (rand_below(40) == 0) lines = lines | 16'($random(seed));
            if (hold_left > 0) begin   // Line held across its ack
                lines[hold_line] = 1'b1;
                hold_left--;
            end else if (rand_below(50) == 0) begin
                hold_line = int'(rand_below(16));
                hold_left = 4 + int'(rand_below(9));
            end
            irq_lines     = lines;
            interrupt_ack = 1'b0;
            if (m_ipend) begin
                if (!armed) begin
                    ack_delay = int'(rand_below(6));
                    armed     = 1'b1;
                end
                if (ack_delay == 0) begin
                    interrupt_ack = 1'b1;
                    armed         = 1'b0;
                end else begin
                    ack_delay--;
                end
            end else if (rand_below(16) == 0) begin
                interrupt_ack = 1'b1;   // Stray ack that must be ignored
            end
        end
    endtask

    initial begin
        int edges;
        rst           = 1'b1;
        irq_lines     = '0;
        mask_register = '0;
        interrupt_ack = 1'b0;
        m_pending     = '0;
        m_state       = M_IDLE;
        m_active      = `IRQ_NONE;
        m_ipend       = 1'b0;
        m_vec         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        check_value("interrupt_pending", 32'(interrupt_pending), 32'h0);
        check_value("active_irq", 32'(active_irq), 32'(`IRQ_NONE));
        check_value("vector_addr", vector_addr, 32'h0);

        // Masked lines must never be presented
        mask_register = 32'hFFFF_00FF;
        for (int i = 0; i < 24; i++) begin
            irq_lines = 16'hFF00;
            advance_cycle();
            check_value("interrupt_pending", 32'(interrupt_pending), 32'h0);
        end
        drain_pending();

        // One-cycle pulse into an idle controller
        mask_register = 32'h0000_FFFF;
        irq_lines     = 16'(1) << 9;
        advance_cycle();
        irq_lines = '0;
        wait_for_presentation(edges);
        check_value("presentation_edges", 32'(edges + 1), 32'd3);
        serve_expected(9, 0, '0);
        drain_pending();

        // Lines 0, 1, 3, 7 and 14 together and line 0 again while 7 waits
        irq_lines = 16'h408B;
        advance_cycle();
        irq_lines = '0;
        serve_expected(1, 0, '0);
        serve_expected(0, 2, '0);
        serve_expected(3, 0, '0);
        serve_expected(7, 5, 16'h0001);
        serve_expected(0, 0, '0);
        serve_expected(14, 1, '0);
        drain_pending();

        // Line held until its ack edge comes back
        irq_lines = 16'(1) << 5;
        wait_for_presentation(edges);
        check_value("active_irq", 32'(active_irq), 32'd5);
        interrupt_ack = 1'b1;
        advance_cycle();
        interrupt_ack = 1'b0;
        irq_lines     = '0;
        wait_for_presentation(edges);
        check_value("active_irq", 32'(active_irq), 32'd5);
        drain_pending();

        run_random(RAND_CYCLES);
        drain_pending();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== irq_ctrl.f ====
+incdir+src
src/irq_pkg.sv
src/irq_capture.sv
src/irq_priority.sv
src/irq_dispatch.sv
src/irq_ctrl.sv
sim/irq_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the irq_ctrl testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary -j 0 -f irq_ctrl.f --top-module irq_ctrl_tb -o irq_ctrl_sim \
    && ./obj_dir/irq_ctrl_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
